//--- dcache_bus_pkg.sv
// packed structs for the core port, the wishbone port and the array command and results
`default_nettype none

package dcache_bus_pkg;

  // ----------------------------------------
  // core side
  // ----------------------------------------
  // fields held stable by the core until gnt
  typedef struct packed {
    logic                  req;
    logic                  we;
    dcache_cfg_pkg::addr_t addr;
    dcache_cfg_pkg::be_t   be;
    dcache_cfg_pkg::word_t wdata;
  } core_req_t;

  typedef struct packed {
    logic                  gnt;
    // rvalid pulses once per load
    logic                  rvalid;
    dcache_cfg_pkg::word_t rdata;
  } core_rsp_t;

  // ----------------------------------------
  // wishbone classic master
  // ----------------------------------------
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    dcache_cfg_pkg::addr_t adr;
    dcache_cfg_pkg::be_t   sel;
    dcache_cfg_pkg::word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    dcache_cfg_pkg::word_t dat;
  } wb_rsp_t;

  // command from the controller to tag and data store
  typedef struct packed {
    logic                     rd;
    dcache_cfg_pkg::set_idx_t set;
    dcache_cfg_pkg::way_vec_t wr_way;
    dcache_cfg_pkg::tag_t     tag;
    logic                     valid;
    logic                     dirty;
    dcache_cfg_pkg::line_t    wline;
    dcache_cfg_pkg::line_be_t wbe;
  } arr_req_t;

  // lookup result, one cycle after rd
  typedef struct packed {
    dcache_cfg_pkg::way_vec_t hit_way;
    dcache_cfg_pkg::way_vec_t victim_way;
    logic                     victim_valid;
    logic                     victim_dirty;
    dcache_cfg_pkg::tag_t     victim_tag;
  } tag_rsp_t;

endpackage

`default_nettype wire

//--- dcache_cfg_pkg.sv
// cache geometry constants and the vector types for addresses, tags, words and lines
`default_nettype none

package dcache_cfg_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  // byte address seen by the core and the bus
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 64;
  localparam int LINE_W         = 128;
  // two ways, one victim pointer bit per set
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 16;
  // address split is tag | set | offset
  localparam int OFFSET_W       = 4;
  localparam int SET_W          = 4;
  localparam int TAG_W          = 24;
  localparam int WORDS_PER_LINE = 2;
  // byte enables per word
  localparam int BE_W           = 8;

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [SET_W-1:0]       set_idx_t;
  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [LINE_W-1:0]      line_t;
  typedef logic [BE_W-1:0]        be_t;
  // one enable per byte of a whole line
  typedef logic [LINE_W/8-1:0]    line_be_t;
  // one bit per way, one-hot or zero
  typedef logic [NUM_WAYS-1:0]    way_vec_t;

endpackage

`default_nettype wire

//--- dcache_ctrl.sv
// request FSM, line buffer for refill and write-back, wishbone master and array command
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      bypass_i,
  output logic                      busy_o,
  input  dcache_bus_pkg::core_req_t core_req_i,
  output dcache_bus_pkg::core_rsp_t core_rsp_o,
  output dcache_bus_pkg::wb_req_t   wb_req_o,
  input  dcache_bus_pkg::wb_rsp_t   wb_rsp_i,
  output dcache_bus_pkg::arr_req_t  arr_req_o,
  input  dcache_bus_pkg::tag_rsp_t  tag_rsp_i,
  input  dcache_cfg_pkg::word_t     rdata_hit_i,
  input  dcache_cfg_pkg::line_t     merged_line_i,
  input  dcache_cfg_pkg::line_be_t  merged_be_i,
  input  dcache_cfg_pkg::line_t     victim_line_i,
  output logic                      req_word_o,
  output dcache_cfg_pkg::be_t       req_be_o,
  output dcache_cfg_pkg::word_t     req_wdata_o
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    EVICT_WB,
    REFILL_RD,
    REFILL_WRITE,
    BYPASS_BEAT
  } state_e;

  state_e    state_d, state_q;
  core_req_t req_d, req_q;
  way_vec_t  way_d, way_q;
  tag_t      vtag_d, vtag_q;
  line_t     buf_d, buf_q;
  logic [$clog2(WORDS_PER_LINE)-1:0] beat_d, beat_q;
  // forces cyc low for one cycle after each ack
  logic      gap_d, gap_q;
  logic      wb_busy;
  logic      wb_done;
  logic      last_beat;
  tag_t      req_tag;
  set_idx_t  req_set;

  assign req_tag     = req_q.addr[ADDR_W-1 -: TAG_W];
  assign req_set     = req_q.addr[OFFSET_W +: SET_W];
  assign req_word_o  = req_q.addr[OFFSET_W-1];
  assign req_be_o    = req_q.be;
  assign req_wdata_o = req_q.wdata;
  assign busy_o      = (state_q != IDLE);
  assign last_beat   = (beat_q == WORDS_PER_LINE - 1);
  assign wb_busy     = (state_q inside {EVICT_WB, REFILL_RD, BYPASS_BEAT}) && !gap_q;
  assign wb_done     = wb_busy && wb_rsp_i.ack;

  // ----------------------------------------
  // wishbone beat
  // ----------------------------------------
  always_comb begin
    wb_req_o.cyc = wb_busy;
    wb_req_o.stb = wb_busy;
    wb_req_o.we  = (state_q == EVICT_WB) || ((state_q == BYPASS_BEAT) && req_q.we);
    wb_req_o.sel = (state_q == BYPASS_BEAT) ? req_q.be : '1;
    wb_req_o.dat = (state_q == BYPASS_BEAT) ? req_q.wdata : buf_q[WORD_W*beat_q +: WORD_W];
    // line beats are word aligned, word 0 first
    case (state_q)
      EVICT_WB:  wb_req_o.adr = {vtag_q, req_set, beat_q, 3'b000};
      REFILL_RD: wb_req_o.adr = {req_tag, req_set, beat_q, 3'b000};
      default:   wb_req_o.adr = {req_q.addr[ADDR_W-1:3], 3'b000};
    endcase
  end

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  always_comb begin
    state_d       = state_q;
    req_d         = req_q;
    way_d         = way_q;
    vtag_d        = vtag_q;
    buf_d         = buf_q;
    beat_d        = beat_q;
    gap_d         = wb_done;
    core_rsp_o    = '0;
    arr_req_o     = '0;
    arr_req_o.set = req_set;
    arr_req_o.tag = req_tag;
    case (state_q)
      IDLE: begin
        if (core_req_i.req) begin
          req_d          = core_req_i;
          // loads are granted on acceptance, stores when written
          core_rsp_o.gnt = !core_req_i.we;
          if (bypass_i) begin
            state_d = BYPASS_BEAT;
          end else begin
            arr_req_o.rd  = 1'b1;
            arr_req_o.set = core_req_i.addr[OFFSET_W +: SET_W];
            arr_req_o.tag = core_req_i.addr[ADDR_W-1 -: TAG_W];
            state_d       = LOOKUP;
          end
        end
      end
      LOOKUP: begin
        if (|tag_rsp_i.hit_way) begin
          way_d = tag_rsp_i.hit_way;
          if (req_q.we) begin
            state_d = STORE_WRITE;
          end else begin
            core_rsp_o.rvalid = 1'b1;
            core_rsp_o.rdata  = rdata_hit_i;
            state_d           = IDLE;
            // overlap the next load with this answer
            if (core_req_i.req && !core_req_i.we && !bypass_i) begin
              core_rsp_o.gnt = 1'b1;
              req_d          = core_req_i;
              arr_req_o.rd   = 1'b1;
              arr_req_o.set  = core_req_i.addr[OFFSET_W +: SET_W];
              arr_req_o.tag  = core_req_i.addr[ADDR_W-1 -: TAG_W];
              state_d        = LOOKUP;
            end
          end
        end else begin
          // miss, keep the victim for write-back
          way_d   = tag_rsp_i.victim_way;
          vtag_d  = tag_rsp_i.victim_tag;
          buf_d   = victim_line_i;
          beat_d  = '0;
          state_d = (tag_rsp_i.victim_valid && tag_rsp_i.victim_dirty) ? EVICT_WB : REFILL_RD;
        end
      end
      STORE_WRITE: begin
        arr_req_o.wr_way = way_q;
        arr_req_o.valid  = 1'b1;
        arr_req_o.dirty  = 1'b1;
        arr_req_o.wline  = merged_line_i;
        arr_req_o.wbe    = merged_be_i;
        core_rsp_o.gnt   = 1'b1;
        state_d          = IDLE;
      end
      EVICT_WB: begin
        if (wb_done) begin
          beat_d = beat_q + 1'b1;
          if (last_beat) begin
            state_d = REFILL_RD;
          end
        end
      end
      REFILL_RD: begin
        if (wb_done) begin
          buf_d[WORD_W*beat_q +: WORD_W] = wb_rsp_i.dat;
          beat_d = beat_q + 1'b1;
          if (last_beat) begin
            state_d = REFILL_WRITE;
          end
        end
      end
      REFILL_WRITE: begin
        // install the clean line and look it up again
        arr_req_o.wr_way = way_q;
        arr_req_o.valid  = 1'b1;
        arr_req_o.wline  = buf_q;
        arr_req_o.wbe    = '1;
        arr_req_o.rd     = 1'b1;
        state_d          = LOOKUP;
      end
      BYPASS_BEAT: begin
        if (wb_done) begin
          core_rsp_o.rvalid = !req_q.we;
          core_rsp_o.gnt    = req_q.we;
          core_rsp_o.rdata  = wb_rsp_i.dat;
          state_d           = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
      gap_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
      gap_q   <= gap_d;
    end
  end

  // held request, victim and line buffer
  always_ff @(posedge clk_i) begin
    req_q  <= req_d;
    way_q  <= way_d;
    vtag_q <= vtag_d;
    buf_q  <= buf_d;
  end

  a_stb_cyc : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_req_o.stb |-> wb_req_o.cyc);
  // a beat waiting for ack keeps its address
  a_beat_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_req_o.stb && !wb_rsp_i.ack |=> wb_req_o.stb && $stable(wb_req_o.adr));
  a_wr_way : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(arr_req_o.wr_way));

endmodule

`default_nettype wire

//--- dcache_data_store.sv
// line array per way and set with byte-masked write and registered read of both ways
`timescale 1ns/1ns
`default_nettype none

module dcache_data_store (
  input  logic                                              clk_i,
  input  dcache_bus_pkg::arr_req_t                          arr_req_i,
  output dcache_cfg_pkg::line_t [dcache_cfg_pkg::NUM_WAYS-1:0] rline_o
);
  import dcache_cfg_pkg::*;

  line_t                mem_q [NUM_WAYS][NUM_SETS];
  // next content of the addressed line in each way
  line_t [NUM_WAYS-1:0] wr_line;

  // ----------------------------------------
  // byte merge
  // ----------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < LINE_W / 8; b++) begin
        if (arr_req_i.wr_way[w] && arr_req_i.wbe[b]) begin
          wr_line[w][8*b +: 8] = arr_req_i.wline[8*b +: 8];
        end else begin
          wr_line[w][8*b +: 8] = mem_q[w][arr_req_i.set][8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // array and read register
  // ----------------------------------------
  // read and write share one set, so a read in the write cycle
  // returns the freshly written line
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr_req_i.wr_way[w]) begin
        mem_q[w][arr_req_i.set] <= wr_line[w];
      end
      if (arr_req_i.rd) begin
        rline_o[w] <= wr_line[w];
      end
    end
  end

endmodule

`default_nettype wire

//--- dcache_line_select.sv
// hit way mux, load word extraction, store merge and victim line mux
`timescale 1ns/1ns
`default_nettype none

module dcache_line_select (
  input  dcache_cfg_pkg::line_t [dcache_cfg_pkg::NUM_WAYS-1:0] rline_i,
  input  dcache_bus_pkg::tag_rsp_t  tag_rsp_i,
  input  logic                      word_sel_i,
  input  dcache_cfg_pkg::be_t       be_i,
  input  dcache_cfg_pkg::word_t     wdata_i,
  output dcache_cfg_pkg::word_t     rdata_hit_o,
  output dcache_cfg_pkg::line_t     merged_line_o,
  output dcache_cfg_pkg::line_be_t  merged_be_o,
  output dcache_cfg_pkg::line_t     victim_line_o
);
  import dcache_cfg_pkg::*;

  line_t hit_line;

  // one-hot way muxes, zero when no way is flagged
  always_comb begin
    hit_line      = '0;
    victim_line_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (tag_rsp_i.hit_way[w]) begin
        hit_line = rline_i[w];
      end
      if (tag_rsp_i.victim_way[w]) begin
        victim_line_o = rline_i[w];
      end
    end
  end

  assign rdata_hit_o = hit_line[WORD_W*word_sel_i +: WORD_W];

  // store data over the hit line, enables at the word position
  always_comb begin
    merged_line_o = hit_line;
    merged_be_o   = '0;
    for (int b = 0; b < BE_W; b++) begin
      if (be_i[b]) begin
        merged_line_o[WORD_W*word_sel_i + 8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
    merged_be_o[BE_W*word_sel_i +: BE_W] = be_i;
  end

endmodule

`default_nettype wire

//--- dcache_tag_store.sv
// tag, valid and dirty arrays with registered lookup, hit detection and victim choice
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_store (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dcache_bus_pkg::arr_req_t arr_req_i,
  output dcache_bus_pkg::tag_rsp_t tag_rsp_o
);
  import dcache_cfg_pkg::*;

  tag_t                   tag_q [NUM_WAYS][NUM_SETS];
  way_vec_t [NUM_SETS-1:0] valid_q;
  way_vec_t [NUM_SETS-1:0] dirty_q;
  // round-robin victim pointer per set
  logic [NUM_SETS-1:0]    ptr_q;
  set_idx_t               set_q;
  tag_t                   look_tag_q;
  way_vec_t               valid_row;
  way_vec_t               dirty_row;
  way_vec_t               victim;

  // tag array and lookup address
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr_req_i.wr_way[w]) begin
        tag_q[w][arr_req_i.set] <= arr_req_i.tag;
      end
    end
    if (arr_req_i.rd) begin
      set_q      <= arr_req_i.set;
      look_tag_q <= arr_req_i.tag;
    end
  end

  // state bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      ptr_q   <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (arr_req_i.wr_way[w]) begin
          valid_q[arr_req_i.set][w] <= arr_req_i.valid;
          dirty_q[arr_req_i.set][w] <= arr_req_i.dirty;
        end
      end
      // a clean write is a refill, stores always write dirty
      if (|arr_req_i.wr_way && !arr_req_i.dirty) begin
        ptr_q[arr_req_i.set] <= ~ptr_q[arr_req_i.set];
      end
    end
  end

  // compare against the set and tag latched with rd
  always_comb begin
    valid_row = valid_q[set_q];
    dirty_row = dirty_q[set_q];
    for (int w = 0; w < NUM_WAYS; w++) begin
      tag_rsp_o.hit_way[w] = valid_row[w] && (tag_q[w][set_q] == look_tag_q);
    end
    // pointer way unless an invalid way is free, lowest first
    victim = '0;
    victim[ptr_q[set_q]] = 1'b1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_row[w]) begin
        victim    = '0;
        victim[w] = 1'b1;
      end
    end
    tag_rsp_o.victim_way   = victim;
    tag_rsp_o.victim_valid = |(valid_row & victim);
    tag_rsp_o.victim_dirty = |(dirty_row & victim);
    tag_rsp_o.victim_tag   = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim[w]) begin
        tag_rsp_o.victim_tag = tag_q[w][set_q];
      end
    end
  end

  // a tag lives in at most one way of its set
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr_req_i.rd |=> $onehot0(tag_rsp_o.hit_way));

endmodule

`default_nettype wire

//--- dcache_top.sv
// data cache top level joining controller, tag store, data store and line selector
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      bypass_i,
  output logic                      busy_o,
  input  dcache_bus_pkg::core_req_t core_req_i,
  output dcache_bus_pkg::core_rsp_t core_rsp_o,
  output dcache_bus_pkg::wb_req_t   wb_req_o,
  input  dcache_bus_pkg::wb_rsp_t   wb_rsp_i
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  // shared array command and lookup results
  arr_req_t             arr_req;
  tag_rsp_t             tag_rsp;
  line_t [NUM_WAYS-1:0] rline;
  // selector results back to the controller
  word_t                rdata_hit;
  line_t                merged_line;
  line_be_t             merged_be;
  line_t                victim_line;
  // held request word fields
  logic                 req_word;
  be_t                  req_be;
  word_t                req_wdata;

  dcache_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bypass_i      (bypass_i),
    .busy_o        (busy_o),
    .core_req_i    (core_req_i),
    .core_rsp_o    (core_rsp_o),
    .wb_req_o      (wb_req_o),
    .wb_rsp_i      (wb_rsp_i),
    .arr_req_o     (arr_req),
    .tag_rsp_i     (tag_rsp),
    .rdata_hit_i   (rdata_hit),
    .merged_line_i (merged_line),
    .merged_be_i   (merged_be),
    .victim_line_i (victim_line),
    .req_word_o    (req_word),
    .req_be_o      (req_be),
    .req_wdata_o   (req_wdata)
  );

  dcache_tag_store u_tag_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .arr_req_i (arr_req),
    .tag_rsp_o (tag_rsp)
  );

  dcache_data_store u_data_store (
    .clk_i     (clk_i),
    .arr_req_i (arr_req),
    .rline_o   (rline)
  );

  dcache_line_select u_line_select (
    .rline_i       (rline),
    .tag_rsp_i     (tag_rsp),
    .word_sel_i    (req_word),
    .be_i          (req_be),
    .wdata_i       (req_wdata),
    .rdata_hit_o   (rdata_hit),
    .merged_line_o (merged_line),
    .merged_be_o   (merged_be),
    .victim_line_o (victim_line)
  );

endmodule

`default_nettype wire

//--- tb_dcache.sv
// data cache testbench with clock, reset, directed tests, compare tasks and shadow memory
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int SEED       = 56;
  localparam int TIMEOUT    = 200;
  localparam int MEM_WORDS  = 1024;
  localparam int MEM_BYTES  = MEM_WORDS * 8;

  logic       clk;
  logic       rst_n;
  logic       bypass;
  logic       busy;
  core_req_t  core_req;
  core_rsp_t  core_rsp;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  // expected memory image, one entry per byte
  logic [7:0] shadow [MEM_BYTES];
  integer     seed;
  int         checks;
  int         errors;
  int         timeouts;

  dcache_top dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .bypass_i   (bypass),
    .busy_o     (busy),
    .core_req_i (core_req),
    .core_rsp_o (core_rsp),
    .wb_req_o   (wb_req),
    .wb_rsp_i   (wb_rsp)
  );

  tb_mem_model #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) u_mem (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout: no %s from the cache within %0d cycles at %0t", what, TIMEOUT, $time);
  endtask

  // ----------------------------------------
  // shadow memory
  // ----------------------------------------
  // initial memory word, the byte address and its inverse
  function automatic word_t fill_word(input addr_t a);
    return {~a, a};
  endfunction

  task automatic init_shadow();
    word_t w;
    for (int i = 0; i < MEM_BYTES; i += 8) begin
      w = fill_word(addr_t'(i));
      for (int k = 0; k < 8; k++) begin
        shadow[i + k] = w[8*k +: 8];
      end
    end
  endtask

  function automatic word_t shadow_word(input addr_t a);
    word_t w;
    for (int k = 0; k < 8; k++) begin
      w[8*k +: 8] = shadow[{a[ADDR_W-1:3], 3'b000} + k];
    end
    return w;
  endfunction

  task automatic shadow_store(input addr_t a, input be_t be, input word_t d);
    for (int k = 0; k < 8; k++) begin
      if (be[k]) begin
        shadow[{a[ADDR_W-1:3], 3'b000} + k] = d[8*k +: 8];
      end
    end
  endtask

  function automatic int beat_total();
    return u_mem.rd_beats + u_mem.wr_beats;
  endfunction

  // ----------------------------------------
  // core access
  // ----------------------------------------
  // called 2 ns after an edge, returns 2 ns after the last edge it used
  task automatic core_access(input logic we, input addr_t addr, input be_t be,
                             input word_t wdata, output word_t rdata);
    int   n;
    logic got;
    rdata          = '0;
    core_req.req   = 1'b1;
    core_req.we    = we;
    core_req.addr  = addr;
    core_req.be    = be;
    core_req.wdata = wdata;
    got = 1'b0;
    n   = 0;
    while (!got && n < TIMEOUT) begin
      @(posedge clk);
      got = core_rsp.gnt;
      n++;
    end
    #DRIVE_DLY;
    core_req = '0;
    if (!got) begin
      report_timeout("gnt");
    end else if (!we) begin
      // loads answer with a single rvalid pulse after the grant
      got = 1'b0;
      n   = 0;
      while (!got && n < TIMEOUT) begin
        @(posedge clk);
        got = core_rsp.rvalid;
        if (got) begin
          rdata = core_rsp.rdata;
        end
        n++;
      end
      #DRIVE_DLY;
      if (!got) begin
        report_timeout("rvalid");
      end
    end
  endtask

  task automatic load_check(input string name, input addr_t addr);
    word_t rdata;
    core_access(1'b0, addr, '1, '0, rdata);
    check_word(name, shadow_word(addr), rdata);
  endtask

  task automatic store_word(input addr_t addr, input be_t be, input word_t wdata);
    word_t rdata;
    core_access(1'b1, addr, be, wdata, rdata);
    shadow_store(addr, be, wdata);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic reset_outputs_low();
    check_bit("reset_gnt", 1'b0, core_rsp.gnt);
    check_bit("reset_rvalid", 1'b0, core_rsp.rvalid);
    check_bit("reset_cyc", 1'b0, wb_req.cyc);
    check_bit("reset_busy", 1'b0, busy);
  endtask

  // miss on set 4 refills the line, the other word then hits
  task automatic cold_load_and_hit();
    int rd0;
    int wr0;
    rd0 = u_mem.rd_beats;
    wr0 = u_mem.wr_beats;
    load_check("cold_load", 32'h0000_0040);
    check_count("cold_load_rd_beats", 2, u_mem.rd_beats - rd0);
    check_count("cold_load_wr_beats", 0, u_mem.wr_beats - wr0);
    rd0 = beat_total();
    load_check("hit_load", 32'h0000_0048);
    check_count("hit_load_beats", 0, beat_total() - rd0);
  endtask

  task automatic partial_store_hit();
    int b0;
    b0 = beat_total();
    store_word(32'h0000_0048, 8'h3C, 64'hDEAD_BEEF_0123_4567);
    load_check("partial_store_load", 32'h0000_0048);
    load_check("partial_store_other_word", 32'h0000_0040);
    check_count("partial_store_beats", 0, beat_total() - b0);
  endtask

  // set 3 gets tags 1 and 2 dirty, tag 3 then evicts the tag 1 line
  task automatic dirty_eviction();
    int rd0;
    int wr0;
    store_word(32'h0000_0130, 8'hFF, 64'h1111_2222_3333_4444);
    store_word(32'h0000_0138, 8'hC3, 64'h5555_6666_7777_8888);
    store_word(32'h0000_0238, 8'h0F, 64'h9999_AAAA_BBBB_CCCC);
    rd0 = u_mem.rd_beats;
    wr0 = u_mem.wr_beats;
    store_word(32'h0000_0330, 8'hF0, 64'hDDDD_EEEE_FFFF_0000);
    check_count("evict_wr_beats", 2, u_mem.wr_beats - wr0);
    check_count("evict_rd_beats", 2, u_mem.rd_beats - rd0);
    check_word("evict_data_w0", shadow_word(32'h0000_0130), u_mem.mem[32'h130 >> 3]);
    check_word("evict_data_w1", shadow_word(32'h0000_0138), u_mem.mem[32'h138 >> 3]);
    load_check("evicted_reload_w0", 32'h0000_0130);
    load_check("evicted_reload_w1", 32'h0000_0138);
    load_check("other_way_reload", 32'h0000_0238);
    load_check("new_line_load", 32'h0000_0330);
  endtask

  task automatic bypass_access();
    int rd0;
    int wr0;
    bypass = 1'b1;
    rd0 = u_mem.rd_beats;
    wr0 = u_mem.wr_beats;
    load_check("bypass_load", 32'h0000_0500);
    check_count("bypass_load_rd_beats", 1, u_mem.rd_beats - rd0);
    check_count("bypass_load_wr_beats", 0, u_mem.wr_beats - wr0);
    check_be("bypass_load_sel", 8'hFF, u_mem.last_sel);
    rd0 = u_mem.rd_beats;
    wr0 = u_mem.wr_beats;
    store_word(32'h0000_0508, 8'h5A, 64'h0F1E_2D3C_4B5A_6978);
    check_count("bypass_store_wr_beats", 1, u_mem.wr_beats - wr0);
    check_count("bypass_store_rd_beats", 0, u_mem.rd_beats - rd0);
    check_be("bypass_store_sel", 8'h5A, u_mem.last_sel);
    check_word("bypass_store_mem", shadow_word(32'h0000_0508), u_mem.mem[32'h508 >> 3]);
    bypass = 1'b0;
  endtask

  // 8 lines, tags 8 to 11 in sets 6 and 7
  task automatic random_traffic();
    logic [31:0] r;
    addr_t       addr;
    word_t       wdata;
    for (int i = 0; i < 200; i++) begin
      r     = $random(seed);
      addr  = 32'h800 + 32'(r[2:1]) * 256 + 32'h60 + 32'(r[0]) * 16 + 32'(r[12]) * 8;
      wdata = {$random(seed), $random(seed)};
      if (r[3]) begin
        store_word(addr, r[11:4], wdata);
      end else begin
        load_check("random_load", addr);
      end
    end
  endtask

  // ----------------------------------------
  // sequence
  // ----------------------------------------
  initial begin
    rst_n    = 1'b0;
    bypass   = 1'b0;
    core_req = '0;
    seed     = SEED;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    init_shadow();
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    reset_outputs_low();
    cold_load_and_hit();
    partial_store_hit();
    dirty_eviction();
    bypass_access();
    random_traffic();
    $display("summary: checks=%0d value_errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// wishbone classic slave memory with random ack delay, beat counters and last sel capture
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
  parameter int MEM_WORDS = 1024,
  parameter int SEED      = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dcache_bus_pkg::wb_req_t wb_req_i,
  output dcache_bus_pkg::wb_rsp_t wb_rsp_o
);
  import dcache_cfg_pkg::*;

  word_t  mem [MEM_WORDS];
  integer seed;
  // cycles left before ack, -1 while no beat is pending
  int     wait_cnt;
  int     idx;
  int     rd_beats;
  int     wr_beats;
  be_t    last_sel;

  // each word holds its own byte address and its inverse
  initial begin
    seed     = SEED;
    wait_cnt = -1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {~addr_t'(i * 8), addr_t'(i * 8)};
    end
  end

  // ----------------------------------------
  // beat handling
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_rsp_o <= '0;
      rd_beats <= 0;
      wr_beats <= 0;
      last_sel <= '0;
      wait_cnt = -1;
    end else begin
      wb_rsp_o.ack <= 1'b0;
      // ack lasts one cycle, the master then drops cyc
      if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack) begin
        if (wait_cnt < 0) begin
          wait_cnt = $random(seed) & 3;
        end
        if (wait_cnt == 0) begin
          idx = wb_req_i.adr[ADDR_W-1:3] % MEM_WORDS;
          wb_rsp_o.ack <= 1'b1;
          wb_rsp_o.dat <= mem[idx];
          last_sel     <= wb_req_i.sel;
          if (wb_req_i.we) begin
            for (int b = 0; b < BE_W; b++) begin
              if (wb_req_i.sel[b]) begin
                mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
              end
            end
            wr_beats <= wr_beats + 1;
          end else begin
            rd_beats <= rd_beats + 1;
          end
          wait_cnt = -1;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
dcache_cfg_pkg.sv
dcache_bus_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_line_select.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv
